// ==== src/aes_dec_config.svh ====
`ifndef AES_DEC_CONFIG_SVH
`define AES_DEC_CONFIG_SVH

// AES-128 only, so the key is four words and the cipher has ten rounds.
`define AES_NK         4
`define AES_NR         10
`define AES_BLOCK_BITS 128
`define AES_WORD_BITS  32

// one stage register for the first key addition and one per round.
`define AES_PIPE_DEPTH (`AES_NR + 1)

`endif

// ==== src/aes_dec_pkg.sv ====
`include "aes_dec_config.svh"

package aes_dec_pkg;

    // byte 0 sits in the leftmost bits and bytes run column by column.
    typedef logic [0:`AES_BLOCK_BITS-1] aes_block_t;
    typedef logic [`AES_WORD_BITS-1:0]  aes_word_t;
    typedef aes_block_t [0:`AES_NR]     aes_round_keys_t;  // entry r is round key r.

    typedef struct packed {
        logic       valid;
        aes_block_t data;
    } aes_stage_s;

    typedef enum logic [1:0] {
        ROUND_ADD_KEY,
        ROUND_FULL,
        ROUND_FINAL
    } aes_round_kind_e;

    typedef enum logic {
        KEY_NONE,
        KEY_READY
    } aes_key_state_e;

    // forward table, needed by the key schedule.
    localparam logic [0:255][7:0] sbox_table = {
        64'h637c777bf26b6fc5,
        64'h3001672bfed7ab76,
        64'hca82c97dfa5947f0,
        64'hadd4a2af9ca472c0,
        64'hb7fd9326363ff7cc,
        64'h34a5e5f171d83115,
        64'h04c723c31896059a,
        64'h071280e2eb27b275,
        64'h09832c1a1b6e5aa0,
        64'h523bd6b329e32f84,
        64'h53d100ed20fcb15b,
        64'h6acbbe394a4c58cf,
        64'hd0efaafb434d3385,
        64'h45f9027f503c9fa8,
        64'h51a3408f929d38f5,
        64'hbcb6da2110fff3d2,
        64'hcd0c13ec5f974417,
        64'hc4a77e3d645d1973,
        64'h60814fdc222a9088,
        64'h46eeb814de5e0bdb,
        64'he0323a0a4906245c,
        64'hc2d3ac629195e479,
        64'he7c8376d8dd54ea9,
        64'h6c56f4ea657aae08,
        64'hba78252e1ca6b4c6,
        64'he8dd741f4bbd8b8a,
        64'h703eb5664803f60e,
        64'h613557b986c11d9e,
        64'he1f8981169d98e94,
        64'h9b1e87e9ce5528df,
        64'h8ca1890dbfe64268,
        64'h41992d0fb054bb16
    };

    localparam logic [0:255][7:0] inv_sbox_table = {
        64'h52096ad53036a538,
        64'hbf40a39e81f3d7fb,
        64'h7ce339829b2fff87,
        64'h348e4344c4dee9cb,
        64'h547b9432a6c2233d,
        64'hee4c950b42fac34e,
        64'h082ea16628d924b2,
        64'h765ba2496d8bd125,
        64'h72f8f66486689816,
        64'hd4a45ccc5d65b692,
        64'h6c704850fdedb9da,
        64'h5e154657a78d9d84,
        64'h90d8ab008cbcd30a,
        64'hf7e45805b8b34506,
        64'hd02c1e8fca3f0f02,
        64'hc1afbd0301138a6b,
        64'h3a9111414f67dcea,
        64'h97f2cfcef0b4e673,
        64'h96ac7422e7ad3585,
        64'he2f937e81c75df6e,
        64'h47f11a711d29c589,
        64'h6fb7620eaa18be1b,
        64'hfc563e4bc6d27920,
        64'h9adbc0fe78cd5af4,
        64'h1fdda8338807c731,
        64'hb11210592780ec5f,
        64'h60517fa919b54a0d,
        64'h2de57a9f93c99cef,
        64'ha0e03b4dae2af5b0,
        64'hc8ebbb3c83539961,
        64'h172b047eba77d626,
        64'he169146355210c7d
    };

    function automatic logic [7:0] gf_xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);  // reduce by the AES polynomial.
    endfunction

    // inverse mix of one column, row 0 in the top byte.
    function automatic aes_word_t gf_mul_inv_col(input aes_word_t col);
        logic [7:0] b  [4];
        logic [7:0] x2 [4];
        logic [7:0] x4 [4];
        logic [7:0] x8 [4];
        aes_word_t  res;
        for (int i = 0; i < 4; i++) begin
            b[i]  = col[31-8*i -: 8];
            x2[i] = gf_xtime(b[i]);
            x4[i] = gf_xtime(x2[i]);
            x8[i] = gf_xtime(x4[i]);
        end
        // each row rotates the {0e, 0b, 0d, 09} coefficients by one.
        for (int r = 0; r < 4; r++) begin
            res[31-8*r -: 8] = (x8[r] ^ x4[r] ^ x2[r])
                             ^ (x8[(r+1)%4] ^ x2[(r+1)%4] ^ b[(r+1)%4])
                             ^ (x8[(r+2)%4] ^ x4[(r+2)%4] ^ b[(r+2)%4])
                             ^ (x8[(r+3)%4] ^ b[(r+3)%4]);
        end
        return res;
    endfunction

endpackage

// ==== src/aes_key_expand.sv ====
`timescale 1ns/10ps
`include "aes_dec_config.svh"

module aes_key_expand (
    input  logic                         clk,
    input  logic                         rst_n,
    input  aes_dec_pkg::aes_block_t      key,
    input  logic                         key_we,
    output aes_dec_pkg::aes_round_keys_t round_keys
);
    import aes_dec_pkg::*;

    localparam int NUM_WORDS = 4 * (`AES_NR + 1);

    aes_word_t       w [NUM_WORDS];
    aes_round_keys_t keys_next;

    function automatic aes_word_t sub_word(input aes_word_t word);
        return {sbox_table[word[31:24]], sbox_table[word[23:16]],
                sbox_table[word[15:8]], sbox_table[word[7:0]]};
    endfunction

    // rcon(n) is x^(n-1) in GF(2^8), placed in the top byte.
    function automatic aes_word_t rcon(input int idx);
        logic [7:0] rc;
        rc = 8'h01;
        for (int j = 1; j < idx; j++) begin
            rc = gf_xtime(rc);
        end
        return {rc, 24'h000000};
    endfunction

    always_comb begin
        for (int i = 0; i < `AES_NK; i++) begin
            w[i] = key[32*i +: 32];
        end
        for (int i = `AES_NK; i < NUM_WORDS; i++) begin
            if (i % `AES_NK == 0) begin
                w[i] = w[i-`AES_NK] ^ sub_word({w[i-1][23:0], w[i-1][31:24]})
                     ^ rcon(i / `AES_NK);
            end else begin
                w[i] = w[i-`AES_NK] ^ w[i-1];
            end
        end
        for (int r = 0; r <= `AES_NR; r++) begin
            keys_next[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            round_keys <= '0;
        end else if (key_we) begin
            round_keys <= keys_next;  // the whole schedule is taken in one edge.
        end
    end

endmodule

// ==== src/aes_inv_round.sv ====
`timescale 1ns/10ps

module aes_inv_round #(
    parameter aes_dec_pkg::aes_round_kind_e kind = aes_dec_pkg::ROUND_FULL
) (
    input  logic                    clk,
    input  aes_dec_pkg::aes_block_t state_in,
    input  aes_dec_pkg::aes_block_t round_key,
    output aes_dec_pkg::aes_block_t state_out
);
    import aes_dec_pkg::*;

    aes_block_t shifted;
    aes_block_t subbed;
    aes_block_t keyed;
    aes_block_t mixed;
    aes_block_t result;

    // row r of each column moves right by r columns.
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted[32*c + 8*r +: 8] = state_in[32*((c - r + 4) % 4) + 8*r +: 8];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            subbed[8*i +: 8] = inv_sbox_table[shifted[8*i +: 8]];
        end
    end

    assign keyed = subbed ^ round_key;

    always_comb begin
        for (int c = 0; c < 4; c++) begin
            mixed[32*c +: 32] = gf_mul_inv_col(keyed[32*c +: 32]);
        end
    end

    // the unused paths drop out once kind is fixed.
    always_comb begin
        case (kind)
            ROUND_ADD_KEY: result = state_in ^ round_key;
            ROUND_FINAL:   result = keyed;
            default:       result = mixed;
        endcase
    end

    always_ff @(posedge clk) begin
        state_out <= result;
    end

endmodule

// ==== src/aes_dec_ctrl.sv ====
`timescale 1ns/10ps
`include "aes_dec_config.svh"

module aes_dec_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic key_load,
    input  logic in_valid,
    output logic key_we,
    output logic key_ready,
    output logic out_valid
);
    import aes_dec_pkg::*;

    aes_key_state_e             state;
    logic [`AES_PIPE_DEPTH-1:0] valid_chain;  // bit k follows the block in stage k.
    logic                       pipe_empty;

    // all stages share the round keys, so a new key must not meet a block in flight.
    assign pipe_empty = (valid_chain == '0) && !in_valid;
    assign key_we     = key_load && pipe_empty;

    assign key_ready = (state == KEY_READY);
    assign out_valid = valid_chain[`AES_PIPE_DEPTH-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= KEY_NONE;
        end else if (key_we) begin
            state <= KEY_READY;  // keys land on the same edge.
        end
    end

    // blocks that arrive before any key is loaded are dropped here.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_chain <= '0;
        end else begin
            valid_chain <= {valid_chain[`AES_PIPE_DEPTH-2:0], in_valid && key_ready};
        end
    end

endmodule

// ==== src/aes_inv_cipher.sv ====
`timescale 1ns/10ps
`include "aes_dec_config.svh"

module aes_inv_cipher (
    input  logic                    clk,
    input  logic                    rst_n,
    input  aes_dec_pkg::aes_block_t key,
    input  logic                    key_load,
    input  aes_dec_pkg::aes_stage_s cipher_in,
    output aes_dec_pkg::aes_stage_s plain_out,
    output logic                    key_ready
);
    import aes_dec_pkg::*;

    logic            key_we;
    logic            out_valid;
    aes_round_keys_t round_keys;
    aes_block_t      stage_data [`AES_PIPE_DEPTH+1];  // entry 0 is the pipeline input.

    // stage 0 adds the last key, the final stage skips the column mix.
    function automatic aes_round_kind_e stage_kind(input int idx);
        if (idx == 0) begin
            return ROUND_ADD_KEY;
        end
        if (idx == `AES_NR) begin
            return ROUND_FINAL;
        end
        return ROUND_FULL;
    endfunction

    aes_dec_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_load  (key_load),
        .in_valid  (cipher_in.valid),
        .key_we    (key_we),
        .key_ready (key_ready),
        .out_valid (out_valid)
    );

    aes_key_expand u_key_expand (
        .clk        (clk),
        .rst_n      (rst_n),
        .key        (key),
        .key_we     (key_we),
        .round_keys (round_keys)
    );

    assign stage_data[0] = cipher_in.data;

    // stage i uses round key Nr - i, so keys are applied in reverse.
    for (genvar i = 0; i < `AES_PIPE_DEPTH; i++) begin : g_round
        aes_inv_round #(
            .kind (stage_kind(i))
        ) u_round (
            .clk       (clk),
            .state_in  (stage_data[i]),
            .round_key (round_keys[`AES_NR - i]),
            .state_out (stage_data[i+1])
        );
    end

    assign plain_out.valid = out_valid;
    assign plain_out.data  = stage_data[`AES_PIPE_DEPTH];

endmodule

// ==== test/aes_dec_assertions.sv ====
`timescale 1ns/10ps
`include "aes_dec_config.svh"

module aes_dec_assertions (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic key_we,
    input logic key_ready,
    input logic out_valid
);
    localparam int LATENCY = `AES_PIPE_DEPTH;

    int fail_count = 0;  // number of failed assertions so far.
    int since_accept;    // edges since the last accepted block, held at LATENCY.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            since_accept <= LATENCY;
        end else if (in_valid && key_ready) begin
            since_accept <= 0;
        end else if (since_accept < LATENCY) begin
            since_accept <= since_accept + 1;
        end
    end

    out_needs_key: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> key_ready)
        else begin
            fail_count++;
            $error("plain output is valid while no key is loaded");
        end

    // an accepted block leaves the last stage after a fixed latency.
    block_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && key_ready) |-> ##LATENCY out_valid)
        else begin
            fail_count++;
            $error("accepted block did not reach the output on time");
        end

    // a block stays in the chain until the edge after it was presented on the output.
    key_only_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        key_we |-> (since_accept == LATENCY))
        else begin
            fail_count++;
            $error("key write while blocks are in flight");
        end

endmodule

bind aes_dec_ctrl aes_dec_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .key_we    (key_we),
    .key_ready (key_ready),
    .out_valid (out_valid)
);

// ==== test/aes_ref_model.svh ====
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// xorshift32 with shifts 13, 17 and 5. A zero state would stay zero.
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

function automatic logic [7:0] times_two(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

// forward AES-128 on byte arrays, where byte i is row i%4 of column i/4.
function automatic aes_block_t encrypt_block(input aes_block_t key, input aes_block_t pt);
    logic [7:0] rk [176];
    logic [7:0] st [16];
    logic [7:0] sh [16];
    logic [7:0] t  [4];
    logic [7:0] rc;
    aes_block_t ct;
    rc = 8'h01;
    for (int i = 0; i < 16; i++) begin
        rk[i] = key[8*i +: 8];
        st[i] = pt[8*i +: 8] ^ key[8*i +: 8];  // initial key addition.
    end
    for (int i = 16; i < 176; i += 4) begin
        for (int j = 0; j < 4; j++) begin
            t[j] = rk[i-4+j];
        end
        if (i % 16 == 0) begin
            // rotate the word, substitute it and add the round constant.
            t[0] = sbox_table[rk[i-3]] ^ rc;
            t[1] = sbox_table[rk[i-2]];
            t[2] = sbox_table[rk[i-1]];
            t[3] = sbox_table[rk[i-4]];
            rc   = times_two(rc);
        end
        for (int j = 0; j < 4; j++) begin
            rk[i+j] = rk[i-16+j] ^ t[j];
        end
    end
    for (int r = 1; r <= 10; r++) begin
        for (int i = 0; i < 16; i++) begin
            sh[i] = sbox_table[st[4*((i/4 + i%4) % 4) + i%4]];  // row k moves left by k.
        end
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                if (r == 10) begin
                    st[4*c+row] = sh[4*c+row];
                end else begin
                    st[4*c+row] = times_two(sh[4*c+row] ^ sh[4*c+(row+1)%4])
                                ^ sh[4*c+(row+1)%4] ^ sh[4*c+(row+2)%4]
                                ^ sh[4*c+(row+3)%4];
                end
                st[4*c+row] = st[4*c+row] ^ rk[16*r + 4*c + row];
            end
        end
    end
    for (int i = 0; i < 16; i++) begin
        ct[8*i +: 8] = st[i];
    end
    return ct;
endfunction

`endif

// ==== test/tb_aes_inv_cipher.sv ====
`timescale 1ns/10ps
`include "aes_dec_config.svh"

module tb_aes_inv_cipher;
    import aes_dec_pkg::*;

    `include "aes_ref_model.svh"

    localparam int LATENCY        = `AES_PIPE_DEPTH;
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    aes_block_t  key;
    logic        key_load;
    aes_stage_s  cipher_in;
    aes_stage_s  plain_out;
    logic        key_ready;

    int          cycle = 0;
    logic [31:0] rng_state = 32'ha6af_d19c;
    aes_block_t  cur_key;
    aes_block_t  exp_data [$];  // plaintexts still in flight, oldest first.
    int          exp_due  [$];

    aes_inv_cipher DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .key       (key),
        .key_load  (key_load),
        .cipher_in (cipher_in),
        .plain_out (plain_out),
        .key_ready (key_ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests ran past %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end else if (DUT.u_ctrl.u_assertions.fail_count != 0) begin
            $display("a controller assertion failed before %0d ns", $time);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_block(input aes_block_t actual, input aes_block_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_state(input aes_key_state_e actual, input aes_key_state_e expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns: %s is %s, expected %s", $time, what, actual.name(),
                     expected.name());
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic aes_block_t random_block();
        return {next_random(), next_random(), next_random(), next_random()};
    endfunction

    // advance one cycle, then compare plain_out with the block due now.
    task automatic tick();
        @(posedge clk);
        #2;
        if (exp_due.size() > 0 && exp_due[0] == cycle) begin
            check_bit(plain_out.valid, 1'b1, "plain_out.valid of a due block");
            check_block(plain_out.data, exp_data.pop_front(), "plaintext");
            void'(exp_due.pop_front());
        end else begin
            check_bit(plain_out.valid, 1'b0, "plain_out.valid with no block due");
        end
    endtask

    task automatic send_block(input aes_block_t ct, input aes_block_t pt);
        cipher_in.valid = 1'b1;
        cipher_in.data  = ct;
        exp_data.push_back(pt);
        exp_due.push_back(cycle + LATENCY);
        tick();
    endtask

    task automatic send_plain(input aes_block_t pt);
        send_block(encrypt_block(cur_key, pt), pt);
    endtask

    task automatic idle(input int n);
        cipher_in.valid = 1'b0;
        repeat (n) tick();
    endtask

    task automatic drain();
        while (exp_due.size() > 0) begin
            idle(1);
        end
        idle(1);  // the last block leaves the valid chain one edge after it is shown.
    endtask

    task automatic load_key(input aes_block_t k);
        key      = k;
        key_load = 1'b1;
        idle(1);
        key_load = 1'b0;
        check_bit(key_ready, 1'b1, "key_ready one cycle after key_load");
        cur_key = k;
    endtask

    task automatic test_reset_and_no_key();
        check_bit(key_ready, 1'b0, "key_ready after reset");
        check_bit(plain_out.valid, 1'b0, "plain_out.valid after reset");
        check_state(DUT.u_ctrl.state, KEY_NONE, "controller state after reset");
        for (int i = 0; i < 5; i++) begin
            cipher_in.valid = 1'b1;
            cipher_in.data  = random_block();
            tick();
        end
        idle(LATENCY + 4);
        check_bit(key_ready, 1'b0, "key_ready with no key loaded");
    endtask

    task automatic test_fips_vector();
        aes_block_t k  = 128'h000102030405060708090a0b0c0d0e0f;
        aes_block_t pt = 128'h00112233445566778899aabbccddeeff;
        aes_block_t ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        check_block(encrypt_block(k, pt), ct, "model ciphertext for the FIPS-197 vector");
        load_key(k);
        send_block(ct, pt);
        drain();
    endtask

    task automatic test_random_stream();
        load_key(random_block());
        for (int i = 0; i < 40; i++) begin
            send_plain(random_block());
            if (i >= 20) begin
                idle(next_random() % 4);  // second half has gaps.
            end
        end
        drain();
    endtask

    task automatic test_key_change_in_flight();
        aes_block_t new_key;
        new_key = random_block();
        for (int i = 0; i < 6; i++) begin
            send_plain(random_block());
        end
        key      = new_key;
        key_load = 1'b1;
        idle(1);
        check_bit(key_ready, 1'b1, "key_ready after a refused key_load");
        key_load = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_plain(random_block());
        end
        drain();
        key_load = 1'b1;
        send_plain(random_block());  // the chain is empty, but a block arrives with the request.
        key_load = 1'b0;
        drain();
        load_key(new_key);
        for (int i = 0; i < 8; i++) begin
            send_plain(random_block());
        end
        drain();
    endtask

    task automatic test_reset_in_flight();
        for (int i = 0; i < 5; i++) begin
            send_plain(random_block());
        end
        rst_n = 1'b0;
        exp_data.delete();
        exp_due.delete();
        idle(1);
        check_bit(key_ready, 1'b0, "key_ready after a reset in flight");
        check_state(DUT.u_ctrl.state, KEY_NONE, "controller state after a reset in flight");
        idle(1);
        rst_n = 1'b1;
        idle(LATENCY + 4);
    endtask

    initial begin
        rst_n     = 1'b0;
        key       = '0;
        key_load  = 1'b0;
        cipher_in = '0;
        cur_key   = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_and_no_key();
        test_fips_vector();
        test_random_stream();
        test_key_change_in_flight();
        test_reset_in_flight();
        if (DUT.u_ctrl.u_assertions.fail_count != 0) begin
            $display("controller assertions failed %0d times",
                     DUT.u_ctrl.u_assertions.fail_count);
            stop_with_failure();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
+incdir+src
+incdir+test
src/aes_dec_pkg.sv
src/aes_key_expand.sv
src/aes_inv_round.sv
src/aes_dec_ctrl.sv
src/aes_inv_cipher.sv
test/aes_dec_assertions.sv
test/tb_aes_inv_cipher.sv
